/* Makefile */
# Verilator build and run of the instruction fetch stage testbench

VERILATOR ?= verilator
TOP       ?= tb_ifu
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --timescale 1ns/1ps
PASS_MSG  ?= Finished with no errors

.PHONY: sim clean

# Build, run, and fail unless the pass line was printed
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

/* flist.f */
src/ifu_pkg.sv
src/ifu_fetch_ctrl.sv
src/ifu_prefetch_fifo.sv
src/ifu_if_id_reg.sv
src/ifu_if_stage.sv
verification/ifu_checker.sv
verification/tb_ifu.sv

/* src/ifu_fetch_ctrl.sv */
/*
  Fetch controller of the IF stage.
  Picks the next PC on a redirect pulse, issues word requests on the
  instruction bus and tracks requests still owed a response.
  Kept responses are pushed into the prefetch FIFO with their address.
*/

`default_nettype none

module ifu_fetch_ctrl #(
  parameter int unsigned FIFO_DEPTH      = 3,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  wire logic                           clk,
  input  wire logic                           rst_n,
  input  wire logic                           pc_set_i,
  input  wire ifu_pkg::pc_mux_e               pc_mux_i,
  input  wire ifu_pkg::addr_t                 boot_addr_i,
  input  wire ifu_pkg::addr_t                 jump_target_i,
  input  wire ifu_pkg::addr_t                 branch_target_i,
  input  wire ifu_pkg::addr_t                 mepc_i,
  input  wire ifu_pkg::mtvec_t                mtvec_addr_i,
  input  wire ifu_pkg::irq_id_t               irq_id_i,
  input  wire logic [$clog2(FIFO_DEPTH+1)-1:0] fifo_count_i,
  input  wire logic                           instr_gnt_i,
  input  wire logic                           instr_rvalid_i,
  input  wire ifu_pkg::instr_t                instr_rdata_i,
  input  wire logic                           instr_err_i,
  output logic                                instr_req_o,
  output ifu_pkg::addr_t                      instr_addr_o,
  output logic                                fifo_push_o,
  output ifu_pkg::instr_t                     fifo_instr_o,
  output ifu_pkg::addr_t                      fifo_addr_o,
  output logic                                fifo_err_o,
  output logic                                fifo_flush_o,
  output logic                                if_busy_o,
  output logic                                csr_mtvec_init_o
);

  localparam int unsigned OUT_W = $clog2(MAX_OUTSTANDING + 1);

  ifu_pkg::addr_t   target;
  ifu_pkg::addr_t   target_aligned;
  ifu_pkg::addr_t   fetch_addr_q;
  ifu_pkg::addr_t   resp_addr_q;
  logic             fetch_en_q;
  logic [OUT_W-1:0] live_cnt_q;
  logic [OUT_W-1:0] discard_cnt_q;
  logic [OUT_W-1:0] total_cnt;
  logic             accepted;
  logic             keep_resp;
  logic             room_fifo;
  logic             room_bus;

  //////////////////////////////////////////////////
  // Target selection
  //////////////////////////////////////////////////

  always_comb begin
    unique case (pc_mux_i)
      ifu_pkg::PC_BOOT:     target = boot_addr_i;
      ifu_pkg::PC_JUMP:     target = jump_target_i;
      ifu_pkg::PC_BRANCH:   target = branch_target_i;
      // Return from exception restores the saved PC
      ifu_pkg::PC_MRET:     target = mepc_i;
      // All exceptions share the base of the vector table
      ifu_pkg::PC_TRAP_EXC: target = {mtvec_addr_i, {ifu_pkg::EXC_OFFSET_W{1'b0}}};
      // Interrupts are vectored by their index, one word per entry
      ifu_pkg::PC_TRAP_IRQ: target = {mtvec_addr_i, irq_id_i, 2'b00};
      default:              target = boot_addr_i;
    endcase
  end

  // Word fetches only, so the two low bits are dropped
  assign target_aligned = {target[31:2], 2'b00};

  // CSR file sets up mtvec whenever the core boots
  assign csr_mtvec_init_o = pc_set_i && (pc_mux_i == ifu_pkg::PC_BOOT);

  //////////////////////////////////////////////////
  // Request side
  //////////////////////////////////////////////////

  assign total_cnt = live_cnt_q + discard_cnt_q;

  // Every live request needs a free FIFO slot when it returns
  assign room_fifo = (32'(fifo_count_i) + 32'(live_cnt_q)) < 32'(FIFO_DEPTH);
  assign room_bus  = 32'(total_cnt) < 32'(MAX_OUTSTANDING);

  assign instr_req_o  = fetch_en_q && room_fifo && room_bus;
  assign instr_addr_o = fetch_addr_q;
  assign accepted     = instr_req_o && instr_gnt_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      fetch_en_q   <= 1'b0;
      fetch_addr_q <= '0;
    end else if (pc_set_i) begin
      // Fetching starts with the first redirect after reset
      fetch_en_q   <= 1'b1;
      fetch_addr_q <= target_aligned;
    end else if (accepted) begin
      fetch_addr_q <= fetch_addr_q + 32'd4;
    end
  end

  //////////////////////////////////////////////////
  // Response side
  //////////////////////////////////////////////////

  // Older responses drain the discard count first, in bus order
  // A response in the redirect cycle still belongs to the old stream
  assign keep_resp = instr_rvalid_i && (discard_cnt_q == '0) && !pc_set_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      live_cnt_q    <= '0;
      discard_cnt_q <= '0;
    end else if (pc_set_i) begin
      // Everything still owed, including this cycle's grant, is thrown away
      discard_cnt_q <= total_cnt + OUT_W'(accepted) - OUT_W'(instr_rvalid_i);
      live_cnt_q    <= '0;
    end else begin
      if (instr_rvalid_i && (discard_cnt_q != '0)) begin
        discard_cnt_q <= discard_cnt_q - 1'b1;
      end
      live_cnt_q <= live_cnt_q + OUT_W'(accepted) - OUT_W'(keep_resp);
    end
  end

  // Address of the next word to come back on the kept stream
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      resp_addr_q <= '0;
    end else if (pc_set_i) begin
      resp_addr_q <= target_aligned;
    end else if (keep_resp) begin
      resp_addr_q <= resp_addr_q + 32'd4;
    end
  end

  assign fifo_push_o  = keep_resp;
  assign fifo_instr_o = instr_rdata_i;
  assign fifo_addr_o  = resp_addr_q;
  assign fifo_err_o   = instr_err_i;
  assign fifo_flush_o = pc_set_i;

  assign if_busy_o = (total_cnt != '0);

endmodule

`default_nettype wire

/* src/ifu_if_id_reg.sv */
/*
  IF/ID pipeline register.
  Takes the FIFO head when IF is valid and decode is ready, and pops it.
  A low ready from decode freezes every output.
*/

`default_nettype none

module ifu_if_id_reg (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            head_valid_i,
  input  wire ifu_pkg::instr_t head_instr_i,
  input  wire ifu_pkg::addr_t  head_addr_i,
  input  wire logic            head_err_i,
  input  wire logic            halt_if_i,
  input  wire logic            id_ready_i,
  output logic                 pop_o,
  output ifu_pkg::addr_t       pc_if_o,
  output logic                 if_id_valid_o,
  output ifu_pkg::instr_t      if_id_instr_o,
  output ifu_pkg::addr_t       if_id_pc_o,
  output logic                 if_id_err_o
);

  logic if_valid;
  logic move;

  //////////////////////////////////////////////////
  // IF valid and handshake
  //////////////////////////////////////////////////

  // Halt holds the head in the FIFO without dropping it
  assign if_valid = head_valid_i && !halt_if_i;
  assign move     = if_valid && id_ready_i;

  assign pop_o   = move;
  // PC of the instruction currently in IF
  assign pc_if_o = head_addr_i;

  //////////////////////////////////////////////////
  // Pipeline register
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      if_id_valid_o <= 1'b0;
    end else if (id_ready_i) begin
      // Decode consumed the old item, so valid follows IF
      if_id_valid_o <= if_valid;
    end
  end

  // Payload only loads on a move
  always_ff @(posedge clk) begin
    if (move) begin
      if_id_instr_o <= head_instr_i;
      if_id_pc_o    <= head_addr_i;
      if_id_err_o   <= head_err_i;
    end
  end

endmodule

`default_nettype wire

/* src/ifu_if_stage.sv */
/*
  Top level of the instruction fetch stage.
  Connects the fetch controller, the prefetch FIFO and the IF/ID register,
  and sets the buffer depth and outstanding limit for all of them.
*/

`default_nettype none

module ifu_if_stage #(
  parameter int unsigned FIFO_DEPTH      = 3,
  parameter int unsigned MAX_OUTSTANDING = 2
) (
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Redirect and targets
  input  wire logic             pc_set_i,
  input  wire ifu_pkg::pc_mux_e pc_mux_i,
  input  wire ifu_pkg::addr_t   boot_addr_i,
  input  wire ifu_pkg::addr_t   jump_target_i,
  input  wire ifu_pkg::addr_t   branch_target_i,
  input  wire ifu_pkg::addr_t   mepc_i,
  input  wire ifu_pkg::mtvec_t  mtvec_addr_i,
  input  wire ifu_pkg::irq_id_t irq_id_i,

  // Flow control from the controller and decode
  input  wire logic             halt_if_i,
  input  wire logic             id_ready_i,

  // Instruction bus
  output logic                  instr_req_o,
  output ifu_pkg::addr_t        instr_addr_o,
  input  wire logic             instr_gnt_i,
  input  wire logic             instr_rvalid_i,
  input  wire ifu_pkg::instr_t  instr_rdata_i,
  input  wire logic             instr_err_i,

  // IF/ID stage and status
  output ifu_pkg::addr_t        pc_if_o,
  output logic                  if_id_valid_o,
  output ifu_pkg::instr_t       if_id_instr_o,
  output ifu_pkg::addr_t        if_id_pc_o,
  output logic                  if_id_err_o,
  output logic                  if_busy_o,
  output logic                  csr_mtvec_init_o
);

  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // Fetch controller to FIFO
  logic             fifo_push;
  ifu_pkg::instr_t  fifo_wr_instr;
  ifu_pkg::addr_t   fifo_wr_addr;
  logic             fifo_wr_err;
  logic             fifo_flush;
  logic [CNT_W-1:0] fifo_count;

  // FIFO head to IF/ID register
  logic             head_valid;
  ifu_pkg::instr_t  head_instr;
  ifu_pkg::addr_t   head_addr;
  logic             head_err;
  logic             head_pop;

  ifu_fetch_ctrl #(
    .FIFO_DEPTH      (FIFO_DEPTH),
    .MAX_OUTSTANDING (MAX_OUTSTANDING)
  ) u_fetch_ctrl (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .boot_addr_i      (boot_addr_i),
    .jump_target_i    (jump_target_i),
    .branch_target_i  (branch_target_i),
    .mepc_i           (mepc_i),
    .mtvec_addr_i     (mtvec_addr_i),
    .irq_id_i         (irq_id_i),
    .fifo_count_i     (fifo_count),
    .instr_gnt_i      (instr_gnt_i),
    .instr_rvalid_i   (instr_rvalid_i),
    .instr_rdata_i    (instr_rdata_i),
    .instr_err_i      (instr_err_i),
    .instr_req_o      (instr_req_o),
    .instr_addr_o     (instr_addr_o),
    .fifo_push_o      (fifo_push),
    .fifo_instr_o     (fifo_wr_instr),
    .fifo_addr_o      (fifo_wr_addr),
    .fifo_err_o       (fifo_wr_err),
    .fifo_flush_o     (fifo_flush),
    .if_busy_o        (if_busy_o),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  ifu_prefetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_prefetch_fifo (
    .clk     (clk),
    .rst_n   (rst_n),
    .push_i  (fifo_push),
    .instr_i (fifo_wr_instr),
    .addr_i  (fifo_wr_addr),
    .err_i   (fifo_wr_err),
    .pop_i   (head_pop),
    .flush_i (fifo_flush),
    .valid_o (head_valid),
    .instr_o (head_instr),
    .addr_o  (head_addr),
    .err_o   (head_err),
    .count_o (fifo_count)
  );

  ifu_if_id_reg u_if_id_reg (
    .clk           (clk),
    .rst_n         (rst_n),
    .head_valid_i  (head_valid),
    .head_instr_i  (head_instr),
    .head_addr_i   (head_addr),
    .head_err_i    (head_err),
    .halt_if_i     (halt_if_i),
    .id_ready_i    (id_ready_i),
    .pop_o         (head_pop),
    .pc_if_o       (pc_if_o),
    .if_id_valid_o (if_id_valid_o),
    .if_id_instr_o (if_id_instr_o),
    .if_id_pc_o    (if_id_pc_o),
    .if_id_err_o   (if_id_err_o)
  );

endmodule

`default_nettype wire

/* src/ifu_pkg.sv */
/*
  Shared types and constants for the instruction fetch stage.
  Every RTL file refers to these by scoped names (ifu_pkg::name).
  Holds the address and word widths, the PC source select and
  the constant that forms the exception trap address.
*/

`default_nettype none

package ifu_pkg;

  //////////////////////////////////////////////////
  // Widths
  //////////////////////////////////////////////////

  localparam int unsigned ADDR_W   = 32;
  localparam int unsigned INSTR_W  = 32;
  // mtvec base keeps bits 31:7 of the trap vector
  localparam int unsigned MTVEC_W  = 25;
  localparam int unsigned IRQ_ID_W = 5;

  // Exception target is mtvec followed by this many zero bits
  localparam int unsigned EXC_OFFSET_W = 7;

  typedef logic [ADDR_W-1:0]   addr_t;
  typedef logic [INSTR_W-1:0]  instr_t;
  typedef logic [MTVEC_W-1:0]  mtvec_t;
  typedef logic [IRQ_ID_W-1:0] irq_id_t;

  //////////////////////////////////////////////////
  // Next PC source
  //////////////////////////////////////////////////

  // Codes 6 and 7 are unused
  typedef enum logic [2:0] {
    PC_BOOT     = 3'd0,
    PC_JUMP     = 3'd1,
    PC_BRANCH   = 3'd2,
    PC_MRET     = 3'd3,
    PC_TRAP_EXC = 3'd4,
    PC_TRAP_IRQ = 3'd5
  } pc_mux_e;

endpackage

`default_nettype wire

/* src/ifu_prefetch_fifo.sv */
/*
  Prefetch FIFO between the instruction bus and the IF/ID register.
  Circular buffer of fetched words, each with its address and bus error.
  A flush clears it in one edge and wins over a push in the same cycle.
*/

`default_nettype none

module ifu_prefetch_fifo #(
  parameter int unsigned FIFO_DEPTH = 3
) (
  input  wire logic                            clk,
  input  wire logic                            rst_n,
  input  wire logic                            push_i,
  input  wire ifu_pkg::instr_t                 instr_i,
  input  wire ifu_pkg::addr_t                  addr_i,
  input  wire logic                            err_i,
  input  wire logic                            pop_i,
  input  wire logic                            flush_i,
  output logic                                 valid_o,
  output ifu_pkg::instr_t                      instr_o,
  output ifu_pkg::addr_t                       addr_o,
  output logic                                 err_o,
  output logic [$clog2(FIFO_DEPTH+1)-1:0]      count_o
);

  localparam int unsigned PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int unsigned CNT_W = $clog2(FIFO_DEPTH + 1);

  // Word, address and error of each buffered entry
  ifu_pkg::instr_t instr_mem [FIFO_DEPTH];
  ifu_pkg::addr_t  addr_mem  [FIFO_DEPTH];
  logic            err_mem   [FIFO_DEPTH];

  logic [PTR_W-1:0] rd_ptr_q;
  logic [PTR_W-1:0] wr_ptr_q;
  logic [CNT_W-1:0] count_q;
  logic             do_push;
  logic             do_pop;

  // Wrap by hand since the depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
    logic [PTR_W-1:0] nxt;
    if (32'(ptr) == FIFO_DEPTH - 1) begin
      nxt = '0;
    end else begin
      nxt = ptr + 1'b1;
    end
    return nxt;
  endfunction

  // Push into a full buffer is ignored, the fetch controller never does it
  assign do_push = push_i && (32'(count_q) < 32'(FIFO_DEPTH));
  assign do_pop  = pop_i && valid_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else if (flush_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_next(wr_ptr_q);
      if (do_pop)  rd_ptr_q <= ptr_next(rd_ptr_q);
      // Push and pop together leave the count alone
      count_q <= count_q + CNT_W'(do_push) - CNT_W'(do_pop);
    end
  end

  always_ff @(posedge clk) begin
    if (do_push && !flush_i) begin
      instr_mem[wr_ptr_q] <= instr_i;
      addr_mem[wr_ptr_q]  <= addr_i;
      err_mem[wr_ptr_q]   <= err_i;
    end
  end

  // Head of the buffer
  assign valid_o = (count_q != '0);
  assign instr_o = instr_mem[rd_ptr_q];
  assign addr_o  = addr_mem[rd_ptr_q];
  assign err_o   = err_mem[rd_ptr_q];
  assign count_o = count_q;

endmodule

`default_nettype wire

/* verification/ifu_checker.sv */
/*
  Checker for the instruction fetch stage testbench.
  Samples the DUT ports at the falling edge, predicts the PC stream from
  each redirect and compares every newly loaded IF/ID item against it,
  together with the IF PC shown just before the load.
*/

`default_nettype none

module ifu_checker (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             pc_set_i,
  input  wire ifu_pkg::pc_mux_e pc_mux_i,
  input  wire ifu_pkg::addr_t   boot_addr_i,
  input  wire ifu_pkg::addr_t   jump_target_i,
  input  wire ifu_pkg::addr_t   branch_target_i,
  input  wire ifu_pkg::addr_t   mepc_i,
  input  wire ifu_pkg::mtvec_t  mtvec_addr_i,
  input  wire ifu_pkg::irq_id_t irq_id_i,
  input  wire ifu_pkg::addr_t   err_addr_i,
  input  wire logic             id_ready_i,
  input  wire logic             instr_req_i,
  input  wire ifu_pkg::addr_t   pc_if_i,
  input  wire logic             if_id_valid_i,
  input  wire ifu_pkg::instr_t  if_id_instr_i,
  input  wire ifu_pkg::addr_t   if_id_pc_i,
  input  wire logic             if_id_err_i,
  input  wire logic             if_busy_i,
  input  wire logic             csr_mtvec_init_i,
  output int                    item_cnt_o,
  output int                    error_cnt_o
);

  timeunit 1ns;
  timeprecision 1ps;

  bit              started;
  bit              pending;
  bit              ready_q;
  ifu_pkg::addr_t  exp_pc;
  ifu_pkg::addr_t  exp_err_addr;
  ifu_pkg::addr_t  next_pc;
  ifu_pkg::addr_t  next_err_addr;
  logic            hold_valid;
  ifu_pkg::instr_t hold_instr;
  ifu_pkg::addr_t  hold_pc;
  logic            hold_err;
  ifu_pkg::addr_t  hold_pc_if;

  // Exceptions land on the mtvec base and interrupts one word apart by index
  function automatic ifu_pkg::addr_t predict_target();
    ifu_pkg::addr_t t;
    case (pc_mux_i)
      ifu_pkg::PC_JUMP:     t = jump_target_i;
      ifu_pkg::PC_BRANCH:   t = branch_target_i;
      ifu_pkg::PC_MRET:     t = mepc_i;
      ifu_pkg::PC_TRAP_EXC: t = 32'(mtvec_addr_i) << 7;
      ifu_pkg::PC_TRAP_IRQ: t = (32'(mtvec_addr_i) << 7) | (32'(irq_id_i) << 2);
      default:              t = boot_addr_i;
    endcase
    return t & ~32'h3;
  endfunction

  task automatic report(input string what, input ifu_pkg::addr_t got,
                        input ifu_pkg::addr_t exp);
    error_cnt_o++;
    $display("ERROR %0t: %s, got %h expected %h", $time, what, got, exp);
  endtask

  task automatic check_item();
    if (!started) begin
      error_cnt_o++;
      $display("ERROR %0t: IF/ID loaded before any redirect", $time);
    end else begin
      // The item that moved was at the FIFO head during the last cycle
      if (hold_pc_if !== exp_pc) report("IF PC before load", hold_pc_if, exp_pc);
      if (if_id_pc_i !== exp_pc) report("IF/ID PC", if_id_pc_i, exp_pc);
      if (if_id_instr_i !== ~exp_pc) report("IF/ID word", if_id_instr_i, ~exp_pc);
      if (if_id_err_i !== (exp_pc == exp_err_addr)) begin
        report("IF/ID bus error", 32'(if_id_err_i), 32'(exp_pc == exp_err_addr));
      end
      exp_pc = exp_pc + 32'd4;
      // An item loaded on the redirect edge is the tail of the old stream
      if (!pending) item_cnt_o++;
    end
  endtask

  always @(negedge clk) begin
    if (!rst_n) begin
      started    = 1'b0;
      pending    = 1'b0;
      item_cnt_o = 0;
    end else begin
      // Nothing may move before the first redirect
      if (!started && !pc_set_i &&
          {instr_req_i, if_id_valid_i, if_busy_i, csr_mtvec_init_i} !== 4'b0000) begin
        error_cnt_o++;
        $display("ERROR %0t: outputs not idle after reset, req/valid/busy/init %b", $time,
                 {instr_req_i, if_id_valid_i, if_busy_i, csr_mtvec_init_i});
      end
      if (csr_mtvec_init_i !== (pc_set_i && pc_mux_i == ifu_pkg::PC_BOOT)) begin
        report("mtvec init", 32'(csr_mtvec_init_i),
               32'(pc_set_i && pc_mux_i == ifu_pkg::PC_BOOT));
      end
      // Ready high at the last edge, so a valid item is new
      if (ready_q && if_id_valid_i === 1'b1) begin
        check_item();
      end else if (!ready_q && {if_id_valid_i, if_id_instr_i, if_id_pc_i, if_id_err_i} !==
                               {hold_valid, hold_instr, hold_pc, hold_err}) begin
        report("IF/ID changed while decode not ready", if_id_pc_i, hold_pc);
      end
      if (pending) begin
        exp_pc       = next_pc;
        exp_err_addr = next_err_addr;
        pending      = 1'b0;
      end
      // DUT takes the redirect at the next rising edge
      if (pc_set_i) begin
        next_pc       = predict_target();
        next_err_addr = err_addr_i;
        pending       = 1'b1;
        started       = 1'b1;
        item_cnt_o    = 0;
      end
    end
    ready_q    = id_ready_i;
    hold_valid = if_id_valid_i;
    hold_instr = if_id_instr_i;
    hold_pc    = if_id_pc_i;
    hold_err   = if_id_err_i;
    hold_pc_if = pc_if_i;
  end

endmodule

`default_nettype wire

/* verification/ifu_tests.txt */
# One redirect per line, hex fields without prefix
# mux: 0 boot, 1 jump, 2 branch, 3 mret, 4 exception trap, 5 interrupt trap
# mux boot jump branch mepc mtvec irq count rdy_stall% halt% gnt_stall% err_addr
0 00001002 00000000 00000000 00000000 0000000 0 12 0 0 0 fffffff0
1 00001000 00002003 00000000 00000000 0000000 0 8 20 10 20 00002010
2 00001000 00002000 00003005 00000000 0000000 0 2 0 0 0 fffffff0
3 00001000 00002000 00003000 0000400a 0000000 0 3 0 0 0 fffffff0
4 00001000 00002000 00003000 00004000 0000123 0 6 10 0 10 00009184
5 00001000 00002000 00003000 00004000 0000123 20 5 0 0 0 fffffff0
1 00001000 00005000 00003000 00004000 0000123 9 40 40 20 30 00005040
0 00000101 00005000 00003000 00004000 0000123 9 1 0 0 0 fffffff0
2 00000100 00005000 00006000 00004000 0000123 9 30 60 30 50 00006020
3 00000100 00005000 00006000 00007001 0000123 9 10 0 0 0 00007004
4 00000100 00005000 00006000 00007000 0000200 9 4 0 0 0 fffffff0
5 00000100 00005000 00006000 00007000 0000200 31 6 30 10 40 00010080
0 00000000 00005000 00006000 00007000 0000200 31 16 25 25 25 00000008
1 00000000 00020001 00006000 00007000 0000200 31 2 0 0 0 fffffff0
2 00000000 00020000 00030000 00007000 0000200 31 20 50 0 0 00030010

/* verification/tb_ifu.sv */
/*
  Testbench top for the instruction fetch stage.
  Reads one redirect per line from the tests file, models the instruction
  bus memory and drives decode flow control at random.
  ifu_checker compares each IF/ID item against the predicted PC stream.
*/

`default_nettype none

module tb_ifu;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int WAIT_LIMIT = 5000;

  logic               clk;
  logic               rst_n;
  logic               pc_set;
  ifu_pkg::pc_mux_e   pc_mux;
  ifu_pkg::addr_t     boot_addr;
  ifu_pkg::addr_t     jump_target;
  ifu_pkg::addr_t     branch_target;
  ifu_pkg::addr_t     mepc;
  ifu_pkg::mtvec_t    mtvec_addr;
  ifu_pkg::irq_id_t   irq_id;
  logic               halt_if;
  logic               id_ready;
  logic               instr_req;
  ifu_pkg::addr_t     instr_addr;
  logic               instr_gnt;
  logic               instr_rvalid;
  ifu_pkg::instr_t    instr_rdata;
  logic               instr_err;
  ifu_pkg::addr_t     pc_if;
  logic               if_id_valid;
  ifu_pkg::instr_t    if_id_instr;
  ifu_pkg::addr_t     if_id_pc;
  logic               if_id_err;
  logic               if_busy;
  logic               csr_mtvec_init;

  // Parameters of the current test line
  ifu_pkg::addr_t     err_addr;
  int                 rdy_stall;
  int                 halt_pct;
  int                 gnt_stall;

  // Checker results
  int                 item_cnt;
  int                 error_cnt;

  // Requests accepted by the memory, oldest first
  ifu_pkg::addr_t     pend_addr[$];
  int                 pend_ready[$];
  int                 cyc;

  always #5 clk = ~clk;

  ifu_if_stage #(
    .FIFO_DEPTH      (3),
    .MAX_OUTSTANDING (2)
  ) DUT (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set),
    .pc_mux_i         (pc_mux),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .irq_id_i         (irq_id),
    .halt_if_i        (halt_if),
    .id_ready_i       (id_ready),
    .instr_req_o      (instr_req),
    .instr_addr_o     (instr_addr),
    .instr_gnt_i      (instr_gnt),
    .instr_rvalid_i   (instr_rvalid),
    .instr_rdata_i    (instr_rdata),
    .instr_err_i      (instr_err),
    .pc_if_o          (pc_if),
    .if_id_valid_o    (if_id_valid),
    .if_id_instr_o    (if_id_instr),
    .if_id_pc_o       (if_id_pc),
    .if_id_err_o      (if_id_err),
    .if_busy_o        (if_busy),
    .csr_mtvec_init_o (csr_mtvec_init)
  );

  ifu_checker u_checker (
    .clk              (clk),
    .rst_n            (rst_n),
    .pc_set_i         (pc_set),
    .pc_mux_i         (pc_mux),
    .boot_addr_i      (boot_addr),
    .jump_target_i    (jump_target),
    .branch_target_i  (branch_target),
    .mepc_i           (mepc),
    .mtvec_addr_i     (mtvec_addr),
    .irq_id_i         (irq_id),
    .err_addr_i       (err_addr),
    .id_ready_i       (id_ready),
    .instr_req_i      (instr_req),
    .pc_if_i          (pc_if),
    .if_id_valid_i    (if_id_valid),
    .if_id_instr_i    (if_id_instr),
    .if_id_pc_i       (if_id_pc),
    .if_id_err_i      (if_id_err),
    .if_busy_i        (if_busy),
    .csr_mtvec_init_i (csr_mtvec_init),
    .item_cnt_o       (item_cnt),
    .error_cnt_o      (error_cnt)
  );

  //////////////////////////////////////////////////
  // Bus memory model
  //////////////////////////////////////////////////

  // Grant and request are stable at the falling edge
  initial begin : bus_memory
    logic           acc;
    ifu_pkg::addr_t acc_addr;
    forever begin
      @(negedge clk);
      acc      = instr_req && instr_gnt;
      acc_addr = instr_addr;
      @(posedge clk);
      #1;
      cyc++;
      // Response shown last cycle was taken at this edge
      if (instr_rvalid && pend_addr.size() > 0) begin
        void'(pend_addr.pop_front());
        void'(pend_ready.pop_front());
      end
      // Latency of 1 to 3 cycles after the grant
      if (acc) begin
        pend_addr.push_back(acc_addr);
        pend_ready.push_back(cyc + int'($urandom_range(2)));
      end
      instr_gnt = int'($urandom_range(99)) >= gnt_stall;
      if (pend_addr.size() > 0 && pend_ready[0] <= cyc) begin
        instr_rvalid = 1'b1;
        instr_rdata  = ~pend_addr[0];
        instr_err    = (pend_addr[0] == err_addr);
      end else begin
        instr_rvalid = 1'b0;
        instr_rdata  = '0;
        instr_err    = 1'b0;
      end
    end
  end

  // Decode ready and halt at the rates of the current line
  initial begin : flow_driver
    forever begin
      @(posedge clk);
      #1;
      if (rst_n) begin
        id_ready = int'($urandom_range(99)) >= rdy_stall;
        halt_if  = int'($urandom_range(99)) < halt_pct;
      end
    end
  end

  //////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////

  task automatic wait_for_items(input int count, output bit stalled);
    int waited;
    waited = 0;
    while (item_cnt < count && waited < WAIT_LIMIT) begin
      @(posedge clk);
      waited++;
    end
    stalled = (item_cnt < count);
  endtask

  initial begin : stimulus
    int               fd;
    string            line;
    int               fields;
    int               mux_val;
    int               count;
    int               t_rdy;
    int               t_halt;
    int               t_gnt;
    ifu_pkg::addr_t   t_boot;
    ifu_pkg::addr_t   t_jump;
    ifu_pkg::addr_t   t_branch;
    ifu_pkg::addr_t   t_mepc;
    ifu_pkg::mtvec_t  t_mtvec;
    ifu_pkg::irq_id_t t_irq;
    ifu_pkg::addr_t   t_err;
    int               tests_run;
    int               stall_cnt;
    bit               stalled;
    clk = 1'b0;
    rst_n = 1'b0;
    pc_set = 1'b0;
    pc_mux = ifu_pkg::PC_BOOT;
    boot_addr = '0;
    jump_target = '0;
    branch_target = '0;
    mepc = '0;
    mtvec_addr = '0;
    irq_id = '0;
    halt_if = 1'b0;
    id_ready = 1'b1;
    instr_gnt = 1'b0;
    instr_rvalid = 1'b0;
    instr_rdata = '0;
    instr_err = 1'b0;
    err_addr = '1;
    rdy_stall = 0;
    halt_pct = 0;
    gnt_stall = 0;
    cyc = 0;
    tests_run = 0;
    stall_cnt = 0;
    stalled = 1'b0;
    void'($urandom(24161));
    repeat (3) @(posedge clk);
    #1;
    rst_n = 1'b1;
    repeat (4) @(posedge clk);
    fd = $fopen("verification/ifu_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open verification/ifu_tests.txt");
    end else begin
      while (!stalled && !$feof(fd)) begin
        line = "";
        void'($fgets(line, fd));
        if (line.len() > 0 && line.getc(0) != "#") begin
          fields = $sscanf(line, "%d %h %h %h %h %h %d %d %d %d %d %h", mux_val, t_boot,
                           t_jump, t_branch, t_mepc, t_mtvec, t_irq, count, t_rdy, t_halt,
                           t_gnt, t_err);
          if (fields == 12) begin
            @(posedge clk);
            #1;
            pc_mux        = ifu_pkg::pc_mux_e'(mux_val);
            boot_addr     = t_boot;
            jump_target   = t_jump;
            branch_target = t_branch;
            mepc          = t_mepc;
            mtvec_addr    = t_mtvec;
            irq_id        = t_irq;
            err_addr      = t_err;
            rdy_stall     = t_rdy;
            halt_pct      = t_halt;
            gnt_stall     = t_gnt;
            pc_set        = 1'b1;
            @(posedge clk);
            #1;
            pc_set = 1'b0;
            tests_run++;
            wait_for_items(count, stalled);
            if (stalled) begin
              stall_cnt++;
              $display("Fetch stalled on test %0d, only %0d of %0d instructions arrived",
                       tests_run, item_cnt, count);
            end
          end
        end
      end
      $fclose(fd);
    end
    repeat (5) @(posedge clk);
    $display("Tests run %0d, check errors %0d, stalled waits %0d", tests_run, error_cnt,
             stall_cnt);
    if (fd != 0 && tests_run > 0 && error_cnt == 0 && stall_cnt == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

`default_nettype wire
